/* design/repeat_pkg.sv */
// Shared widths, counts, vector typedefs and the configuration struct of the block repeater

package repeat_pkg;

  // Stream word width
  localparam int DATA_W = 16;

  // Number of repeating buffer lanes
  localparam int NUM_LANES = 2;

  // Largest repeat count and block size
  localparam int MAX_REPEAT = 4;
  localparam int MAX_SIZE   = 8;

  // RAM address with a floor of one bit
  localparam int ADDR_W = ($clog2(MAX_SIZE) < 1) ? 1 : $clog2(MAX_SIZE);

  // Pointers and fill counts must reach MAX_SIZE itself
  localparam int PTR_W  = ADDR_W + 1;
  localparam int REP_W  = $clog2(MAX_REPEAT + 1);
  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Counts one full repeated group of a block
  localparam int WCNT_W = $clog2(MAX_SIZE * MAX_REPEAT + 1);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [REP_W-1:0]  rep_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [WCNT_W-1:0] word_cnt_t;

  // Repeat count 1 to MAX_REPEAT and block size 1 to MAX_SIZE
  typedef struct packed {
    rep_t repeat_n;
    ptr_t size_n;
  } cfg_t;

endpackage

/* design/sdp_ram.sv */
// Simple dual-port RAM with one write port and a registered read port
`timescale 1ns/100ps

module sdp_ram
  import repeat_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_din,
  input  addr_t rd_addr,
  output data_t rd_dout
);

  data_t mem [MAX_SIZE];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_din;
    end
  end

  // Read data comes out one cycle after the address
  always_ff @(posedge clk) begin
    rd_dout <= mem[rd_addr];
  end

endmodule

/* design/repeat_buffer.sv */
// Repeating circular buffer that replays each stored block with a two-register output skid
`timescale 1ns/100ps

module repeat_buffer
  import repeat_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  cfg_t  cfg,
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  // One skid register slot
  typedef struct packed {
    logic  valid;
    data_t data;
  } skid_reg_t;

  typedef struct packed {
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    ptr_t      fill;
    rep_t      rep;
    logic      rd_pend;
    logic      sel;
    skid_reg_t out_reg;
    skid_reg_t extra_reg;
  } buf_state_t;

  buf_state_t st;
  buf_state_t st_nxt;

  logic       last_rep;
  logic       last_addr;
  logic       wr_done;
  logic       rd_blocked;
  logic       wr_fire;
  logic       rd_fire;
  logic       room;
  logic       pop;
  logic       head_nxt;
  logic       tail_sel;
  logic [1:0] pending;
  skid_reg_t  head;
  data_t      ram_dout;

  assign last_rep  = (st.rep == cfg.repeat_n - rep_t'(1));
  assign last_addr = (st.rd_ptr == cfg.size_n - ptr_t'(1));
  assign wr_done   = (st.wr_ptr == cfg.size_n);

  // First pass reads never reach the address still to be written
  assign rd_blocked = (st.rep == '0) && !last_rep && (st.rd_ptr == st.wr_ptr);

  // Full buffer or finished block waiting for its final repeat
  assign in_ready = (st.fill != cfg.size_n) && !wr_done;
  assign wr_fire  = in_valid && in_ready;

  // Oldest skid entry drives the output
  assign head      = st.sel ? st.extra_reg : st.out_reg;
  assign out_data  = head.data;
  assign out_valid = head.valid;
  assign pop       = head.valid && out_ready;

  // Skid words plus the word now leaving the RAM
  assign pending = {1'b0, st.out_reg.valid} + {1'b0, st.extra_reg.valid} + {1'b0, st.rd_pend};

  // A new read needs a free slot when its data arrives
  assign room = (pending < 2'd2) || ((pending == 2'd2) && pop);

  assign rd_fire = (st.fill != '0) && !rd_blocked && room;

  always_comb begin
    st_nxt = st;

    // Write side rewinds once the final repeat of the block has begun
    if (wr_fire) begin
      st_nxt.wr_ptr = st.wr_ptr + ptr_t'(1);
    end else if (wr_done && last_rep) begin
      st_nxt.wr_ptr = '0;
    end

    // Read side walks the block once per repeat
    st_nxt.rd_pend = rd_fire;
    if (rd_fire) begin
      if (last_addr) begin
        st_nxt.rd_ptr = '0;
        st_nxt.rep    = last_rep ? '0 : st.rep + rep_t'(1);
      end else begin
        st_nxt.rd_ptr = st.rd_ptr + ptr_t'(1);
      end
    end

    // Words are released only by reads of the final repeat
    st_nxt.fill = st.fill + ptr_t'(wr_fire) - ptr_t'(rd_fire && last_rep);

    // Skid drains in arrival order
    if (pop) begin
      if (st.sel) begin
        st_nxt.extra_reg.valid = 1'b0;
      end else begin
        st_nxt.out_reg.valid = 1'b0;
      end
    end

    // Head moves on a pop and new data goes behind any word left
    head_nxt   = st.sel ^ pop;
    tail_sel   = head_nxt ^ (st_nxt.out_reg.valid || st_nxt.extra_reg.valid);
    st_nxt.sel = head_nxt;

    if (st.rd_pend) begin
      if (tail_sel) begin
        st_nxt.extra_reg.valid = 1'b1;
        st_nxt.extra_reg.data  = ram_dout;
      end else begin
        st_nxt.out_reg.valid = 1'b1;
        st_nxt.out_reg.data  = ram_dout;
      end
    end
  end

  sdp_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_fire),
    .wr_addr (st.wr_ptr[ADDR_W-1:0]),
    .wr_din  (in_data),
    .rd_addr (st.rd_ptr[ADDR_W-1:0]),
    .rd_dout (ram_dout)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      st.wr_ptr          <= '0;
      st.rd_ptr          <= '0;
      st.fill            <= '0;
      st.rep             <= '0;
      st.rd_pend         <= 1'b0;
      st.sel             <= 1'b0;
      st.out_reg.valid   <= 1'b0;
      st.extra_reg.valid <= 1'b0;
    end else begin
      st <= st_nxt;
    end
  end

endmodule

/* design/lane_splitter.sv */
// Round-robin splitter that sends whole input blocks to the buffer lanes
`timescale 1ns/100ps

module lane_splitter
  import repeat_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  cfg_t                 cfg,
  input  data_t                in_data,
  input  logic                 in_valid,
  output logic                 in_ready,
  output data_t                lane_in_data [NUM_LANES],
  output logic [NUM_LANES-1:0] lane_in_valid,
  input  logic [NUM_LANES-1:0] lane_in_ready
);

  lane_t lane;
  ptr_t  word_cnt;
  logic  fire;
  logic  last_word;

  // Only the current lane sees valid
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_in_data[k]  = in_data;
      lane_in_valid[k] = in_valid && (lane == lane_t'(k));
    end
  end

  assign in_ready  = lane_in_ready[lane];
  assign fire      = in_valid && in_ready;
  assign last_word = (word_cnt == cfg.size_n - ptr_t'(1));

  // Next lane after the last word of a block
  always_ff @(posedge clk) begin
    if (rst) begin
      lane     <= '0;
      word_cnt <= '0;
    end else if (fire) begin
      if (last_word) begin
        word_cnt <= '0;
        if (lane == lane_t'(NUM_LANES - 1)) begin
          lane <= '0;
        end else begin
          lane <= lane + lane_t'(1);
        end
      end else begin
        word_cnt <= word_cnt + ptr_t'(1);
      end
    end
  end

endmodule

/* design/lane_merger.sv */
// Round-robin merger that drains each repeated block group from the lanes in input order
`timescale 1ns/100ps

module lane_merger
  import repeat_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  cfg_t                 cfg,
  input  data_t                lane_out_data [NUM_LANES],
  input  logic [NUM_LANES-1:0] lane_out_valid,
  output logic [NUM_LANES-1:0] lane_out_ready,
  output data_t                out_data,
  output logic                 out_valid,
  input  logic                 out_ready
);

  lane_t     lane;
  word_cnt_t word_cnt;
  word_cnt_t group_len;
  logic      fire;
  logic      last_word;

  // One group is a block times its repeat count
  assign group_len = word_cnt_t'(cfg.size_n) * word_cnt_t'(cfg.repeat_n);

  assign out_data  = lane_out_data[lane];
  assign out_valid = lane_out_valid[lane];
  assign fire      = out_valid && out_ready;
  assign last_word = (word_cnt == group_len - word_cnt_t'(1));

  // Only the current lane sees ready
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_out_ready[k] = out_ready && (lane == lane_t'(k));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane     <= '0;
      word_cnt <= '0;
    end else if (fire) begin
      if (last_word) begin
        word_cnt <= '0;
        if (lane == lane_t'(NUM_LANES - 1)) begin
          lane <= '0;
        end else begin
          lane <= lane + lane_t'(1);
        end
      end else begin
        word_cnt <= word_cnt + word_cnt_t'(1);
      end
    end
  end

endmodule

/* design/repeat_stream_top.sv */
// Top level of the block repeater with splitter, buffer lanes and merger
`timescale 1ns/100ps

module repeat_stream_top
  import repeat_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  cfg_t  cfg,
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  // Splitter to buffers
  data_t                lane_in_data [NUM_LANES];
  logic [NUM_LANES-1:0] lane_in_valid;
  logic [NUM_LANES-1:0] lane_in_ready;

  // Buffers to merger
  data_t                lane_out_data [NUM_LANES];
  logic [NUM_LANES-1:0] lane_out_valid;
  logic [NUM_LANES-1:0] lane_out_ready;

  lane_splitter u_splitter (
    .clk           (clk),
    .rst           (rst),
    .cfg           (cfg),
    .in_data       (in_data),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .lane_in_data  (lane_in_data),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    repeat_buffer u_buf (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .in_data   (lane_in_data[k]),
      .in_valid  (lane_in_valid[k]),
      .in_ready  (lane_in_ready[k]),
      .out_data  (lane_out_data[k]),
      .out_valid (lane_out_valid[k]),
      .out_ready (lane_out_ready[k])
    );
  end

  lane_merger u_merger (
    .clk            (clk),
    .rst            (rst),
    .cfg            (cfg),
    .lane_out_data  (lane_out_data),
    .lane_out_valid (lane_out_valid),
    .lane_out_ready (lane_out_ready),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

endmodule

/* testbench/tb_repeat_stream.sv */
// Table-driven testbench for the block repeater with reference queue, back-pressure and watchdog
`timescale 1ns/100ps

module tb_repeat_stream
  import repeat_pkg::*;
;

  localparam int NUM_TESTS = 5;
  localparam logic [31:0] SEED = 32'h2ad5;

  // One stimulus row with its expected output word count
  typedef struct packed {
    int repeat_n;
    int size_n;
    int blocks;
    bit gaps;
    bit stalls;
    int exp_words;
  } test_row_t;

  logic  clk;
  logic  rst;
  cfg_t  cfg;
  data_t in_data;
  logic  in_valid;
  logic  in_ready;
  data_t out_data;
  logic  out_valid;
  logic  out_ready;

  test_row_t   rows [NUM_TESTS];
  test_row_t   row;
  data_t       expected [$];
  data_t       exp_word;
  logic [31:0] data_state;
  logic [31:0] gap_state;
  logic [31:0] stall_state;
  bit          stall_on;
  int          cur_test;
  int          rx_count;
  int          test_errors;
  int          pass_count;
  int          fail_count;
  int          limit;

  repeat_stream_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h (test %0d)", name, exp, act, cur_test);
      test_errors++;
    end
  endtask

  // Random back-pressure keeps ready high three cycles out of four
  initial begin
    stall_state = xorshift32(SEED);
    forever begin
      @(posedge clk);
      #2;
      if (stall_on) begin
        stall_state = xorshift32(stall_state);
        out_ready = (stall_state[1:0] != 2'd0);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // Output transfers are taken at the falling edge where the handshake is stable
  always @(negedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (expected.size() == 0) begin
        $display("test %0d: output word %h arrived when no word was expected", cur_test, out_data);
        test_errors++;
      end else begin
        exp_word = expected.pop_front();
        check_value("out_data", exp_word, out_data);
      end
      rx_count++;
    end
  end

  task automatic apply_reset(input test_row_t r);
    rst          = 1'b1;
    in_valid     = 1'b0;
    cfg.repeat_n = rep_t'(r.repeat_n);
    cfg.size_n   = ptr_t'(r.size_n);
    stall_on     = r.stalls;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  task automatic send_word(input data_t w);
    in_data  = w;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic send_block(input int size, input int reps, input bit gaps);
    data_t blk [MAX_SIZE];
    int    gap;
    for (int i = 0; i < size; i++) begin
      data_state = xorshift32(data_state);
      blk[i] = data_state[DATA_W-1:0];
    end
    // Reference model pushes the whole block once per repeat
    for (int r = 0; r < reps; r++) begin
      for (int i = 0; i < size; i++) begin
        expected.push_back(blk[i]);
      end
    end
    for (int i = 0; i < size; i++) begin
      send_word(blk[i]);
      if (gaps) begin
        gap_state = xorshift32(gap_state);
        gap = gap_state[1:0];
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    cfg       = '0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    stall_on  = 1'b0;
    cur_test  = 0;
    rx_count  = 0;
    pass_count = 0;
    fail_count = 0;

    // repeat_n, size_n, blocks, gaps, stalls, expected words
    rows[0] = '{1, 1, 16, 1'b0, 1'b0, 16};
    rows[1] = '{3, 4, 6, 1'b0, 1'b0, 72};
    rows[2] = '{MAX_REPEAT, MAX_SIZE, 6, 1'b0, 1'b1, 192};
    rows[3] = '{MAX_REPEAT, MAX_SIZE, 6, 1'b1, 1'b1, 192};
    rows[4] = '{2, 5, 7, 1'b1, 1'b1, 70};

    limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += rows[t].blocks * rows[t].size_n * rows[t].repeat_n * 8 + 100;
    end

    fork
      begin
        repeat (limit) @(posedge clk);
        $display("timeout: test %0d did not finish within %0d cycles", cur_test, limit);
        $display("sim failed");
        $finish;
      end
    join_none

    for (int t = 0; t < NUM_TESTS; t++) begin
      row         = rows[t];
      cur_test    = t;
      test_errors = 0;
      rx_count    = 0;
      expected.delete();
      // Same data for every row so gap rows can be compared to gapless ones
      data_state = SEED;
      gap_state  = xorshift32(SEED ^ 32'h5a5a);
      apply_reset(row);
      @(negedge clk);
      check_value("out_valid", 1'b0, out_valid);
      // Empty buffers accept the first word
      check_value("in_ready", 1'b1, in_ready);
      @(posedge clk);
      #2;
      for (int b = 0; b < row.blocks; b++) begin
        send_block(row.size_n, row.repeat_n, row.gaps);
      end
      while (rx_count < row.exp_words) @(posedge clk);
      #2;
      if (expected.size() != 0) begin
        $display("test %0d: %0d expected words never came out", t, expected.size());
        test_errors++;
      end
      // Nothing more may appear once the stream has drained
      repeat (20) begin
        @(negedge clk);
        check_value("out_valid", 1'b0, out_valid);
      end
      check_value("word_count", row.exp_words, rx_count);
      @(posedge clk);
      #2;
      $display("test %0d repeat %0d size %0d blocks %0d words %0d errors %0d", t,
               row.repeat_n, row.size_n, row.blocks, rx_count, test_errors);
      if (test_errors == 0) begin
        pass_count++;
      end else begin
        fail_count++;
      end
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* project.f */
design/repeat_pkg.sv
design/sdp_ram.sv
design/repeat_buffer.sv
design/lane_splitter.sv
design/lane_merger.sv
design/repeat_stream_top.sv
testbench/tb_repeat_stream.sv

/* Bender.yml */
package:
  name: repeat_stream

sources:
  - files:
      - design/repeat_pkg.sv
      - design/sdp_ram.sv
      - design/repeat_buffer.sv
      - design/lane_splitter.sv
      - design/lane_merger.sv
      - design/repeat_stream_top.sv
  - target: test
    files:
      - testbench/tb_repeat_stream.sv
